// ==== design/simframe_pkg.sv ====
// ================================================
// Shared definitions for the pattern streamer
// Register map, reset values, response codes and bus structs
// ================================================

package simframe_pkg;

   // Bump whenever the register map changes
   parameter logic [31:0] MODULE_VERSION = 32'd1;

   // ================================================
   // Register word indices, taken from byte address bits 6..2
   // ================================================
   parameter logic [4:0] REG_MODULE_REV     = 5'd0;   // RO
   parameter logic [4:0] REG_FIFO_CTL       = 5'd1;   // Bit n clears FIFO n
   parameter logic [4:0] REG_LOAD_F0        = 5'd2;   // W loads a word, R gives count
   parameter logic [4:0] REG_LOAD_F1        = 5'd3;
   parameter logic [4:0] REG_START          = 5'd4;   // 0 stop, 1 FIFO 0, 2 FIFO 1
   parameter logic [4:0] REG_CYCLES_PER_PKT = 5'd5;
   parameter logic [4:0] REG_PKTS_PER_FRAME = 5'd6;

   // Byte address width on the register port
   parameter int ADDR_W = 8;

   // Geometry after reset
   parameter logic [15:0] DEFAULT_CYCLES_PER_PKT = 16'd32;
   parameter logic [15:0] DEFAULT_PKTS_PER_FRAME = 16'd2048;

   // FIFO clear hold-off in cycles
   parameter int CLEAR_CYCLES = 15;

   // Response codes
   parameter logic [1:0] RESP_OKAY   = 2'd0;
   parameter logic [1:0] RESP_DECERR = 2'd3;

   // Register request, pulses are one cycle wide
   typedef struct packed {
      logic              write;
      logic              read;
      logic [ADDR_W-1:0] addr;
      logic [31:0]       wdata;
   } reg_req_t;

   // Register response
   typedef struct packed {
      logic        write_done;
      logic        read_valid;
      logic [31:0] rdata;
      logic [1:0]  resp;
   } reg_rsp_t;

   // Frame geometry handed to downstream logic
   typedef struct packed {
      logic [15:0] cycles_per_pkt;
      logic [15:0] pkts_per_frame;
   } frame_geom_t;

   // One-hot FIFO select, 0 is none
   typedef logic [1:0] fifo_sel_t;

endpackage

// ==== design/pattern_fifo.sv ====
`timescale 1ns/1ps
// ================================================
// Synchronous first-word-fall-through FIFO for one word type
// clear empties it, storage keeps stale contents
// ================================================

module pattern_fifo #(
   parameter type pattern_t  = logic [31:0],
   parameter int  FIFO_DEPTH = 64,
   parameter int  COUNT_W    = 7
) (
   input  logic     clk,
   input  logic     resetn,
   input  logic     clear,
   input  logic     push,
   input  pattern_t push_data,
   input  logic     pop,
   output pattern_t head,
   output logic     head_valid,
   output logic     full
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);

   pattern_t           mem [FIFO_DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [COUNT_W-1:0] fill;
   logic               do_push;
   logic               do_pop;

   // Occupancy flags
   assign full       = (fill == COUNT_W'(FIFO_DEPTH));
   assign head_valid = (fill != '0);

   // Fall-through read of the oldest entry
   assign head = mem[rd_ptr];

   // Overflow and underflow are dropped here, assertions flag them
   assign do_push = push && !full;
   assign do_pop  = pop && head_valid;

   // Storage array
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // ================================================
   // Pointers and fill level
   // ================================================
   always_ff @(posedge clk) begin
      if (!resetn || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         // Pointers wrap at the last slot, depth need not be a power of 2
         if (do_push) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         // Push and pop together leave fill unchanged
         fill <= fill + COUNT_W'(do_push) - COUNT_W'(do_pop);
      end
   end

   // Loop feedback never overfills, sequencer pops only a valid head
   a_no_push_full: assert property (
      @(posedge clk) disable iff (!resetn) push |-> !full);
   a_no_pop_empty: assert property (
      @(posedge clk) disable iff (!resetn) pop |-> head_valid);

endmodule

// ==== design/pattern_loop.sv ====
`timescale 1ns/1ps
// ================================================
// One recirculating pattern store
// Loads go in directly, popped words are fed back one cycle later
// ================================================

module pattern_loop #(
   parameter type pattern_t  = logic [31:0],
   parameter int  FIFO_DEPTH = 64,
   parameter int  COUNT_W    = 7
) (
   input  logic               clk,
   input  logic               resetn,
   input  logic               clear,
   input  logic               load,
   input  pattern_t           load_data,
   input  logic               pop,
   output pattern_t           head,
   output logic               head_valid,
   output logic [COUNT_W-1:0] count
);

   logic     fb_valid;
   pattern_t fb_data;
   logic     full;
   logic     push;
   pattern_t push_data;

   // Feedback request, dropped by a clear
   always_ff @(posedge clk) begin
      if (!resetn || clear) begin
         fb_valid <= 1'b0;
      end else begin
         fb_valid <= pop && head_valid;
      end
   end

   // Word just popped, written back on the next cycle
   always_ff @(posedge clk) begin
      fb_data <= head;
   end

   // Feedback wins the push mux; a load into a full FIFO is dropped
   assign push      = fb_valid || (load && !full);
   assign push_data = fb_valid ? fb_data : load_data;

   // Entries loaded so far, this is the length of one pass
   always_ff @(posedge clk) begin
      if (!resetn || clear) begin
         count <= '0;
      end else if (load && !full) begin
         count <= count + 1'b1;
      end
   end

   pattern_fifo #(
      .pattern_t  (pattern_t),
      .FIFO_DEPTH (FIFO_DEPTH),
      .COUNT_W    (COUNT_W)
   ) fifo (
      .clk        (clk),
      .resetn     (resetn),
      .clear      (clear),
      .push       (push),
      .push_data  (push_data),
      .pop        (pop),
      .head       (head),
      .head_valid (head_valid),
      .full       (full)
   );

   // Register block only loads an inactive FIFO, whose feedback has drained
   a_no_load_on_fb: assert property (
      @(posedge clk) disable iff (!resetn) !(load && fb_valid));

endmodule

// ==== design/simframe_regs.sv ====
`timescale 1ns/1ps
// ================================================
// Register block on the strobe request/response port
// Holds clear hold-off, START selection and frame geometry
// ================================================

module simframe_regs #(
   parameter int PATTERN_WIDTH = 32,
   parameter int COUNT_W       = 7
) (
   input  logic                       clk,
   input  logic                       resetn,
   input  simframe_pkg::reg_req_t     req,
   output simframe_pkg::reg_rsp_t     rsp,
   input  logic [COUNT_W-1:0]         count0,
   input  logic [COUNT_W-1:0]         count1,
   input  simframe_pkg::fifo_sel_t    active,
   output logic [1:0]                 load,
   output logic [PATTERN_WIDTH-1:0]   load_data,
   output logic [1:0]                 clear,
   output simframe_pkg::fifo_sel_t    on_deck,
   output simframe_pkg::frame_geom_t  geom
);

   localparam int CLR_W = $clog2(simframe_pkg::CLEAR_CYCLES + 1);

   logic [1:0][CLR_W-1:0] clr_cnt;
   logic                  clr_wait;
   logic                  write_done;
   logic [1:0]            wresp;
   logic                  read_valid;
   logic [31:0]           rdata;
   logic [1:0]            rresp;
   logic [4:0]            idx;
   logic [1:0]            clr_ok;
   logic [15:0]           geom_val;

   // Word index shared by reads and writes
   assign idx = req.addr[6:2];

   // Clear requests that hit an idle FIFO
   assign clr_ok = req.wdata[1:0] & ~active;

   // Geometry writes need a nonzero value and no active FIFO
   assign geom_val = req.wdata[15:0];

   // A FIFO is held in clear while its counter runs
   assign clear[0] = (clr_cnt[0] != '0);
   assign clear[1] = (clr_cnt[1] != '0);

   // ================================================
   // Write side
   // ================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         clr_cnt    <= '0;
         clr_wait   <= 1'b0;
         write_done <= 1'b0;
         load       <= 2'b00;
         on_deck    <= 2'b00;
         geom       <= '{cycles_per_pkt: simframe_pkg::DEFAULT_CYCLES_PER_PKT,
                         pkts_per_frame: simframe_pkg::DEFAULT_PKTS_PER_FRAME};
      end else begin
         load       <= 2'b00;
         write_done <= 1'b0;

         // Hold-off counters run down to zero
         for (int n = 0; n < 2; n++) begin
            if (clr_cnt[n] != '0) begin
               clr_cnt[n] <= clr_cnt[n] - 1'b1;
            end
         end

         if (clr_wait) begin
            // Done only once both FIFOs are out of clear
            if (clr_cnt[0] == '0 && clr_cnt[1] == '0) begin
               clr_wait   <= 1'b0;
               write_done <= 1'b1;
            end
         end else if (req.write) begin
            write_done <= 1'b1;
            wresp      <= simframe_pkg::RESP_OKAY;
            case (idx)
               simframe_pkg::REG_FIFO_CTL: begin
                  for (int n = 0; n < 2; n++) begin
                     if (clr_ok[n]) begin
                        clr_cnt[n] <= CLR_W'(simframe_pkg::CLEAR_CYCLES);
                     end
                  end
                  if (clr_ok != 2'b00) begin
                     clr_wait   <= 1'b1;
                     write_done <= 1'b0;
                  end
                  // An emptied FIFO cannot stay on deck
                  if ((clr_ok & on_deck) != 2'b00) begin
                     on_deck <= 2'b00;
                  end
               end
               simframe_pkg::REG_LOAD_F0: begin
                  if (!active[0]) begin
                     load      <= 2'b01;
                     load_data <= req.wdata[PATTERN_WIDTH-1:0];
                  end
               end
               simframe_pkg::REG_LOAD_F1: begin
                  if (!active[1]) begin
                     load      <= 2'b10;
                     load_data <= req.wdata[PATTERN_WIDTH-1:0];
                  end
               end
               simframe_pkg::REG_START: begin
                  // Never both FIFOs, never an empty one
                  if (req.wdata[1:0] == 2'b00) begin
                     on_deck <= 2'b00;
                  end else if (req.wdata[1:0] == 2'b01 && count0 != '0) begin
                     on_deck <= 2'b01;
                  end else if (req.wdata[1:0] == 2'b10 && count1 != '0) begin
                     on_deck <= 2'b10;
                  end
               end
               simframe_pkg::REG_CYCLES_PER_PKT: begin
                  if (geom_val != '0 && active == 2'b00) begin
                     geom.cycles_per_pkt <= geom_val;
                  end
               end
               simframe_pkg::REG_PKTS_PER_FRAME: begin
                  if (geom_val != '0 && active == 2'b00) begin
                     geom.pkts_per_frame <= geom_val;
                  end
               end
               default: wresp <= simframe_pkg::RESP_DECERR;
            endcase
         end
      end
   end

   // ================================================
   // Read side, data one cycle after the pulse
   // ================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         read_valid <= 1'b0;
      end else begin
         read_valid <= req.read;
      end
   end

   always_ff @(posedge clk) begin
      if (req.read) begin
         rresp <= simframe_pkg::RESP_OKAY;
         case (idx)
            simframe_pkg::REG_MODULE_REV:     rdata <= simframe_pkg::MODULE_VERSION;
            simframe_pkg::REG_FIFO_CTL:       rdata <= {30'd0, clear};
            simframe_pkg::REG_LOAD_F0:        rdata <= 32'(count0);
            simframe_pkg::REG_LOAD_F1:        rdata <= 32'(count1);
            simframe_pkg::REG_START:          rdata <= {30'd0, active};
            simframe_pkg::REG_CYCLES_PER_PKT: rdata <= {16'd0, geom.cycles_per_pkt};
            simframe_pkg::REG_PKTS_PER_FRAME: rdata <= {16'd0, geom.pkts_per_frame};
            default: begin
               rdata <= 32'd0;
               rresp <= simframe_pkg::RESP_DECERR;
            end
         endcase
      end
   end

   // Only one request is outstanding, so one resp field serves both
   assign rsp.write_done = write_done;
   assign rsp.read_valid = read_valid;
   assign rsp.rdata      = rdata;
   assign rsp.resp       = read_valid ? rresp : wresp;

endmodule

// ==== design/stream_sequencer.sv ====
`timescale 1ns/1ps
// ================================================
// Output sequencer, streams the active FIFO pass by pass
// Selection changes only after the last word of a pass
// ================================================

module stream_sequencer #(
   parameter type pattern_t = logic [31:0],
   parameter int  COUNT_W   = 7
) (
   input  logic                    clk,
   input  logic                    resetn,
   input  simframe_pkg::fifo_sel_t on_deck,
   input  logic [COUNT_W-1:0]      count0,
   input  logic [COUNT_W-1:0]      count1,
   input  pattern_t                head0,
   input  pattern_t                head1,
   input  logic                    head_valid0,
   input  logic                    head_valid1,
   output logic [1:0]              pops,
   output simframe_pkg::fifo_sel_t active,
   output pattern_t                stream_data,
   output logic                    stream_valid,
   input  logic                    stream_ready
);

   logic [COUNT_W-1:0] pass_cnt;
   logic               handshake;
   logic               pass_end;

   // Valid also waits out the recirculation gap at the head
   assign stream_valid = (active[0] && head_valid0) || (active[1] && head_valid1);
   assign stream_data  = active[1] ? head1 : head0;
   assign handshake    = stream_valid && stream_ready;

   // Only the active FIFO pops
   assign pops = active & {2{handshake}};

   // Last word of the current pass is leaving
   assign pass_end = handshake && (pass_cnt == COUNT_W'(1));

   // ================================================
   // Pass FSM, idle whenever active is none
   // ================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         active   <= 2'b00;
         pass_cnt <= '0;
      end else if (active == 2'b00 || pass_end) begin
         // Continue, switch or stop from the on-deck select
         active   <= on_deck;
         pass_cnt <= on_deck[1] ? count1 : count0;
      end else if (handshake) begin
         pass_cnt <= pass_cnt - 1'b1;
      end
   end

   // START decode in the register block keeps the select one-hot
   a_active_one_hot: assert property (
      @(posedge clk) disable iff (!resetn) active != 2'b11);

endmodule

// ==== design/simframe_ctl.sv ====
`timescale 1ns/1ps
// ================================================
// Pattern streamer top level
// Register port in, repeating pattern stream and frame geometry out
// ================================================

module simframe_ctl #(
   parameter int PATTERN_WIDTH = 32,
   parameter int FIFO_DEPTH    = 64
) (
   input  logic                      clk,
   input  logic                      resetn,
   input  simframe_pkg::reg_req_t    req,
   output simframe_pkg::reg_rsp_t    rsp,
   output logic [PATTERN_WIDTH-1:0]  stream_data,
   output logic                      stream_valid,
   input  logic                      stream_ready,
   output simframe_pkg::frame_geom_t geom
);

   // Counts run from 0 to FIFO_DEPTH inclusive
   localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);

   typedef logic [PATTERN_WIDTH-1:0] pattern_t;

   logic [1:0]              load;
   pattern_t                load_data;
   logic [1:0]              clear;
   logic [1:0]              pops;
   simframe_pkg::fifo_sel_t on_deck;
   simframe_pkg::fifo_sel_t active;
   logic [COUNT_W-1:0]      count0;
   logic [COUNT_W-1:0]      count1;
   pattern_t                head0;
   pattern_t                head1;
   logic                    head_valid0;
   logic                    head_valid1;

   // ================================================
   // Register block
   // ================================================
   simframe_regs #(
      .PATTERN_WIDTH (PATTERN_WIDTH),
      .COUNT_W       (COUNT_W)
   ) regs (
      .clk       (clk),
      .resetn    (resetn),
      .req       (req),
      .rsp       (rsp),
      .count0    (count0),
      .count1    (count1),
      .active    (active),
      .load      (load),
      .load_data (load_data),
      .clear     (clear),
      .on_deck   (on_deck),
      .geom      (geom)
   );

   // ================================================
   // Pattern stores, both take the same load word
   // ================================================
   pattern_loop #(
      .pattern_t  (pattern_t),
      .FIFO_DEPTH (FIFO_DEPTH),
      .COUNT_W    (COUNT_W)
   ) loop_0 (
      .clk        (clk),
      .resetn     (resetn),
      .clear      (clear[0]),
      .load       (load[0]),
      .load_data  (load_data),
      .pop        (pops[0]),
      .head       (head0),
      .head_valid (head_valid0),
      .count      (count0)
   );

   pattern_loop #(
      .pattern_t  (pattern_t),
      .FIFO_DEPTH (FIFO_DEPTH),
      .COUNT_W    (COUNT_W)
   ) loop_1 (
      .clk        (clk),
      .resetn     (resetn),
      .clear      (clear[1]),
      .load       (load[1]),
      .load_data  (load_data),
      .pop        (pops[1]),
      .head       (head1),
      .head_valid (head_valid1),
      .count      (count1)
   );

   // Output sequencer
   stream_sequencer #(
      .pattern_t (pattern_t),
      .COUNT_W   (COUNT_W)
   ) seq (
      .clk          (clk),
      .resetn       (resetn),
      .on_deck      (on_deck),
      .count0       (count0),
      .count1       (count1),
      .head0        (head0),
      .head1        (head1),
      .head_valid0  (head_valid0),
      .head_valid1  (head_valid1),
      .pops         (pops),
      .active       (active),
      .stream_data  (stream_data),
      .stream_valid (stream_valid),
      .stream_ready (stream_ready)
   );

endmodule

// ==== bench/simframe_model.svh ====
// ================================================
// Bench model for the pattern streamer, included inside the testbench
// Random source, expected stream word and value checks
// ================================================

`ifndef SIMFRAME_MODEL_SVH
`define SIMFRAME_MODEL_SVH

// 32-bit xorshift step, state must never be zero
function automatic logic [31:0] xorshift32(input logic [31:0] state);
   logic [31:0] s;
   s = state;
   s = s ^ (s << 13);
   s = s ^ (s >> 17);
   s = s ^ (s << 5);
   return s;
endfunction

// Expected word at one position of a pass through the selected FIFO
function automatic logic [31:0] expected_word(input logic [1:0] fifo, input int pos);
   logic [31:0] word;
   if (fifo[1]) begin
      word = pat1[pos];
   end else begin
      word = pat0[pos];
   end
   return word;
endfunction

// Plain-word failure, ends the run
task automatic end_with_failure(input string why);
   $display("%s", why);
   $display("Simulation failed");
   $fatal(1);
endtask

// Value compare, mismatch shows both sides in hex
task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
   if (got !== expected) begin
      end_with_failure($sformatf("ERROR %s: got 0x%08h, expected 0x%08h",
                                 name, got, expected));
   end
endtask

`endif

// ==== bench/simframe_tb.sv ====
`timescale 1ns/1ps
// ================================================
// Testbench for the pattern streamer top level
// Register tasks drive the port, a model process checks each stream word
// ================================================

module simframe_tb;

   localparam int PATTERN_WIDTH = 32;
   localparam int FIFO_DEPTH    = 64;
   // About 60 register accesses and 40 stream words fit many times over
   localparam int MAX_CYCLES    = 4000;

   logic                      clk;
   logic                      resetn;
   simframe_pkg::reg_req_t    req;
   simframe_pkg::reg_rsp_t    rsp;
   logic [PATTERN_WIDTH-1:0]  stream_data;
   logic                      stream_valid;
   logic                      stream_ready;
   simframe_pkg::frame_geom_t geom;

   // Patterns as loaded, lengths count only accepted loads
   logic [31:0] pat0 [FIFO_DEPTH];
   logic [31:0] pat1 [FIFO_DEPTH];
   int          len0;
   int          len1;

   // Reference state of the stream, owned by the compare process
   logic [1:0]  ref_fifo;
   logic [1:0]  ref_on_deck;
   int          ref_pos;
   int          ref_len;
   int          words_f0;
   int          words_f1;

   logic [31:0] data_state;
   logic [31:0] ready_state;
   int          cycles;

   `include "simframe_model.svh"

   simframe_ctl #(
      .PATTERN_WIDTH (PATTERN_WIDTH),
      .FIFO_DEPTH    (FIFO_DEPTH)
   ) DUT (.*);

   // 100 ns clock
   always #50 clk = ~clk;

   // Run length guard
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         end_with_failure($sformatf("Timeout, no result after %0d cycles", MAX_CYCLES));
      end
   end

   // Back-pressure, ready on roughly 7 cycles of 10
   always @(negedge clk) begin
      if (resetn) begin
         ready_state = xorshift32(ready_state);
         stream_ready <= (ready_state % 32'd10) < 32'd7;
      end
   end

   // ================================================
   // Stream model and compare
   // ================================================
   always @(posedge clk) begin
      if (!resetn) begin
         ref_fifo    = 2'b00;
         ref_on_deck = 2'b00;
         ref_pos     = 0;
         ref_len     = 0;
         words_f0    = 0;
         words_f1    = 0;
      end else begin
         if (ref_fifo == 2'b00) begin
            // Idle, the on-deck select is taken on every edge
            if (stream_valid) begin
               end_with_failure("stream_valid rose while no FIFO was active");
            end
            ref_fifo = ref_on_deck;
            ref_len  = ref_on_deck[1] ? len1 : len0;
            ref_pos  = 0;
         end else if (stream_valid && stream_ready) begin
            check_value("stream_data", stream_data, expected_word(ref_fifo, ref_pos));
            if (ref_fifo[1]) begin
               words_f1 = words_f1 + 1;
            end else begin
               words_f0 = words_f0 + 1;
            end
            ref_pos = ref_pos + 1;
            // Pass boundary, continue, switch or stop
            if (ref_pos == ref_len) begin
               ref_fifo = ref_on_deck;
               ref_len  = ref_on_deck[1] ? len1 : len0;
               ref_pos  = 0;
            end
         end
         // START rule, 0 always, 1 or 2 only for a loaded FIFO, 3 ignored
         if (req.write && req.addr[6:2] == simframe_pkg::REG_START) begin
            if (req.wdata[1:0] == 2'b00) begin
               ref_on_deck = 2'b00;
            end else if (req.wdata[1:0] == 2'b01 && len0 != 0) begin
               ref_on_deck = 2'b01;
            end else if (req.wdata[1:0] == 2'b10 && len1 != 0) begin
               ref_on_deck = 2'b10;
            end
         end
      end
   end

   // ================================================
   // Register port access
   // ================================================
   task automatic write_reg(input logic [4:0] idx, input logic [31:0] data,
                            output logic [1:0] resp, output int latency);
      @(negedge clk);
      req.write = 1'b1;
      req.addr  = {1'b0, idx, 2'b00};
      req.wdata = data;
      @(negedge clk);
      req.write = 1'b0;
      latency   = 1;
      // Clear writes hold write-done back until the hold-off ends
      while (!rsp.write_done) begin
         @(negedge clk);
         latency = latency + 1;
      end
      resp = rsp.resp;
   endtask

   task automatic read_reg(input logic [4:0] idx, output logic [31:0] data,
                           output logic [1:0] resp);
      @(negedge clk);
      req.read = 1'b1;
      req.addr = {1'b0, idx, 2'b00};
      @(negedge clk);
      req.read = 1'b0;
      while (!rsp.read_valid) begin
         @(negedge clk);
      end
      data = rsp.rdata;
      resp = rsp.resp;
   endtask

   task automatic write_okay(input logic [4:0] idx, input logic [31:0] data);
      logic [1:0] resp;
      int         latency;
      write_reg(idx, data, resp, latency);
      check_value("rsp.resp", resp, simframe_pkg::RESP_OKAY);
   endtask

   task automatic read_expect(input string name, input logic [4:0] idx,
                              input logic [31:0] expected);
      logic [31:0] data;
      logic [1:0]  resp;
      read_reg(idx, data, resp);
      check_value("rsp.resp", resp, simframe_pkg::RESP_OKAY);
      check_value(name, data, expected);
   endtask

   // Random words, bit 31 marks FIFO 1
   task automatic load_pattern(input int fifo, input int n);
      logic [31:0] w;
      for (int i = 0; i < n; i++) begin
         data_state = xorshift32(data_state);
         if (fifo == 1) begin
            w = data_state | 32'h8000_0000;
            write_okay(simframe_pkg::REG_LOAD_F1, w);
            pat1[len1] = w;
            len1       = len1 + 1;
         end else begin
            w = data_state & 32'h7fff_ffff;
            write_okay(simframe_pkg::REG_LOAD_F0, w);
            pat0[len0] = w;
            len0       = len0 + 1;
         end
      end
   endtask

   // ================================================
   // Test sequence
   // ================================================
   initial begin
      logic [31:0] data;
      logic [1:0]  resp;
      int          latency;
      clk          = 1'b0;
      resetn       = 1'b0;
      req          = '0;
      stream_ready = 1'b0;
      data_state   = 32'd89;
      ready_state  = 32'd89;
      cycles       = 0;
      len0         = 0;
      len1         = 0;
      repeat (2) @(negedge clk);
      resetn = 1'b1;

      // Reset values
      read_expect("module_rev", simframe_pkg::REG_MODULE_REV, 32'd1);
      read_expect("cycles_per_pkt", simframe_pkg::REG_CYCLES_PER_PKT, 32'd32);
      read_expect("pkts_per_frame", simframe_pkg::REG_PKTS_PER_FRAME, 32'd2048);
      check_value("geom.cycles_per_pkt", geom.cycles_per_pkt, 32'd32);
      check_value("geom.pkts_per_frame", geom.pkts_per_frame, 32'd2048);
      check_value("stream_valid", stream_valid, 32'd0);

      // FIFO 0 repeats 5 words for 3 passes
      load_pattern(0, 5);
      read_expect("count0", simframe_pkg::REG_LOAD_F0, 32'd5);
      write_okay(simframe_pkg::REG_START, 32'd1);
      while (words_f0 < 15) begin
         @(negedge clk);
      end

      // Switch to FIFO 1 while FIFO 0 streams
      load_pattern(1, 3);
      write_okay(simframe_pkg::REG_START, 32'd2);
      while (words_f1 < 9) begin
         @(negedge clk);
      end
      read_expect("start", simframe_pkg::REG_START, 32'd2);

      // Stop lands on a pass boundary
      write_okay(simframe_pkg::REG_START, 32'd0);
      while (ref_fifo != 2'b00) begin
         @(negedge clk);
      end
      read_expect("start", simframe_pkg::REG_START, 32'd0);

      // Refusals while FIFO 1 streams
      write_okay(simframe_pkg::REG_START, 32'd2);
      while (ref_fifo != 2'b10) begin
         @(negedge clk);
      end
      write_okay(simframe_pkg::REG_LOAD_F1, 32'h8000_1234);
      read_expect("count1", simframe_pkg::REG_LOAD_F1, 32'd3);
      write_okay(simframe_pkg::REG_CYCLES_PER_PKT, 32'd7);
      read_expect("cycles_per_pkt", simframe_pkg::REG_CYCLES_PER_PKT, 32'd32);
      check_value("geom.cycles_per_pkt", geom.cycles_per_pkt, 32'd32);
      write_reg(5'd9, 32'h1, resp, latency);
      check_value("rsp.resp", resp, simframe_pkg::RESP_DECERR);
      read_reg(5'd9, data, resp);
      check_value("rsp.resp", resp, simframe_pkg::RESP_DECERR);
      check_value("rsp.rdata", data, 32'd0);
      write_okay(simframe_pkg::REG_START, 32'd0);
      while (ref_fifo != 2'b00) begin
         @(negedge clk);
      end

      // Clear of idle FIFO 0, done only after the hold-off
      write_reg(simframe_pkg::REG_FIFO_CTL, 32'd1, resp, latency);
      check_value("rsp.resp", resp, simframe_pkg::RESP_OKAY);
      if (latency <= simframe_pkg::CLEAR_CYCLES) begin
         end_with_failure("Clear write-done came before the hold-off ended");
      end
      len0 = 0;
      read_expect("count0", simframe_pkg::REG_LOAD_F0, 32'd0);
      write_okay(simframe_pkg::REG_START, 32'd1);
      read_expect("start", simframe_pkg::REG_START, 32'd0);
      repeat (20) @(negedge clk);
      check_value("stream_valid", stream_valid, 32'd0);

      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+bench
design/simframe_pkg.sv
design/pattern_fifo.sv
design/pattern_loop.sv
design/simframe_regs.sv
design/stream_sequencer.sv
design/simframe_ctl.sv
bench/simframe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator and run, the pass line in the output decides the status
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module simframe_tb -Mdir obj_dir \
   && ./obj_dir/Vsimframe_tb | tee /dev/stderr | grep -q "Simulation passed" \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }
